/* Bender.yml */
package:
  name: muldiv_apb

sources:
  - src/muldiv_pkg.sv
  - src/seq_div.sv
  - src/seq_mul.sv
  - src/muldiv_core.sv
  - src/muldiv_apb_regs.sv
  - src/muldiv_apb.sv
  - target: test
    include_dirs:
      - testbench
    files:
      - testbench/tb_muldiv.sv

/* list.f */
+incdir+testbench
src/muldiv_pkg.sv
src/seq_div.sv
src/seq_mul.sv
src/muldiv_core.sv
src/muldiv_apb_regs.sv
src/muldiv_apb.sv
testbench/tb_muldiv.sv

/* src/muldiv_apb.sv */
// Multiply/divide coprocessor top level
// APB register block driving the arithmetic core
`timescale 1ns/1ps
`default_nettype none

module muldiv_apb import muldiv_pkg::*; #(
    parameter int ADDR_W = 8
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              psel,
    input  logic              penable,
    input  logic              pwrite,
    input  logic [ADDR_W-1:0] paddr,
    input  logic [APB_DW-1:0] pwdata,
    output logic [APB_DW-1:0] prdata,
    output logic              pready,
    output logic              pslverr
);

    // Register block to core
    logic             start;
    muldiv_op_e       op;
    logic             len;
    logic [31:0]      opa;
    logic [15:0]      opb;
    // Core back to registers
    logic             busy, done, v;
    logic [RES_W-1:0] res_lo, res_hi;

    muldiv_apb_regs #(
        .ADDR_W (ADDR_W)
    ) u_regs (
        .clk     (clk),
        .rst     (rst),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .start   (start),
        .op      (op),
        .len     (len),
        .opa     (opa),
        .opb     (opb),
        .busy    (busy),
        .done    (done),
        .v       (v),
        .res_lo  (res_lo),
        .res_hi  (res_hi)
    );

    muldiv_core u_core (
        .clk    (clk),
        .rst    (rst),
        .start  (start),
        .op     (op),
        .len    (len),
        .opa    (opa),
        .opb    (opb),
        .busy   (busy),
        .done   (done),
        .v      (v),
        .res_lo (res_lo),
        .res_hi (res_hi)
    );

endmodule

`default_nettype wire

/* src/muldiv_apb_regs.sv */
// APB register block for the multiply/divide coprocessor
// Operand, control, status and result registers
`timescale 1ns/1ps
`default_nettype none

module muldiv_apb_regs import muldiv_pkg::*; #(
    parameter int ADDR_W = 8
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              psel,
    input  logic              penable,
    input  logic              pwrite,
    input  logic [ADDR_W-1:0] paddr,
    input  logic [APB_DW-1:0] pwdata,
    output logic [APB_DW-1:0] prdata,
    output logic              pready,
    output logic              pslverr,
    output logic              start,    // One-cycle pulse to the core
    output muldiv_op_e        op,
    output logic              len,
    output logic [31:0]       opa,
    output logic [15:0]       opb,
    input  logic              busy,
    input  logic              done,
    input  logic              v,
    input  logic [RES_W-1:0]  res_lo,
    input  logic [RES_W-1:0]  res_hi
);

    logic access, wr_en, rd_en;
    logic hit_opa, hit_opb, hit_ctrl, hit_status, hit_lo, hit_hi;
    logic mapped;
    logic ctrl_wr;

    // ********************************************************
    // Decode
    // ********************************************************
    assign access     = psel && penable;        // Access phase
    assign wr_en      = access && pwrite;
    assign rd_en      = access && !pwrite;

    assign hit_opa    = paddr == ADDR_W'(REG_OPA);
    assign hit_opb    = paddr == ADDR_W'(REG_OPB);
    assign hit_ctrl   = paddr == ADDR_W'(REG_CTRL);
    assign hit_status = paddr == ADDR_W'(REG_STATUS);
    assign hit_lo     = paddr == ADDR_W'(REG_RES_LO);
    assign hit_hi     = paddr == ADDR_W'(REG_RES_HI);
    assign mapped     = hit_opa || hit_opb || hit_ctrl || hit_status || hit_lo || hit_hi;

    assign pready     = 1'b1;                   // No wait states
    assign pslverr    = access && !mapped;

    // Start while busy drops the whole CTRL write
    assign ctrl_wr    = wr_en && hit_ctrl && !(busy && pwdata[CTRL_START]);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            start <= 1'b0;
            op    <= OP_MUL;
            len   <= 1'b0;
        end else begin
            start <= ctrl_wr && pwdata[CTRL_START];
            if (ctrl_wr) begin
                op  <= muldiv_op_e'(pwdata[1:0]);
                len <= pwdata[CTRL_LEN];
            end
        end
    end

    // Operands, rewritable while busy
    always_ff @(posedge clk) begin
        if (wr_en && hit_opa)
            opa <= pwdata;
        if (wr_en && hit_opb)
            opb <= pwdata[15:0];
    end

    // ********************************************************
    // Read mux
    // ********************************************************
    always_comb begin
        prdata = '0;
        if (rd_en) begin
            if (hit_opa)
                prdata = APB_DW'(opa);
            else if (hit_opb)
                prdata = APB_DW'(opb);
            else if (hit_ctrl)
                prdata = APB_DW'({len, op});        // Start reads as 0
            else if (hit_status)
                prdata = APB_DW'({done, v, busy});
            else if (hit_lo)
                prdata = APB_DW'(res_lo);
            else if (hit_hi)
                prdata = APB_DW'(res_hi);
        end
    end

endmodule

`default_nettype wire

/* src/muldiv_core.sv */
// Multiply/divide sequencer
// Magnitudes in, one unit run, signs restored on the way out
`timescale 1ns/1ps
`default_nettype none

module muldiv_core import muldiv_pkg::*; (
    input  logic             clk,
    input  logic             rst,
    input  logic             start,     // One-cycle pulse
    input  muldiv_op_e       op,
    input  logic             len,       // 1 = word
    input  logic [31:0]      opa,
    input  logic [15:0]      opb,
    output logic             busy,
    output logic             done,      // Sticky until next start
    output logic             v,
    output logic [RES_W-1:0] res_lo,
    output logic [RES_W-1:0] res_hi
);

    core_state_e state;
    muldiv_op_e  op_r;
    logic        len_r;
    logic        launched;              // Unit has seen its start edge
    logic [31:0] a_r;                   // Operand magnitudes
    logic [15:0] b_r;
    logic        neg_res;               // Product or quotient negative
    logic        neg_rem;               // Remainder follows dividend

    logic        is_div, is_signed;
    logic        sa, sb;
    logic        div_go, mul_go;
    logic        div_busy, div_v, mul_busy, unit_busy;
    logic [15:0] quot, rem;
    logic [31:0] prod, prod_s;
    logic [15:0] quot_s, rem_s, qlim;
    logic        sovf;

    assign is_div    = (op_r == OP_DIV) || (op_r == OP_DIVS);
    assign is_signed = (op_r == OP_MULS) || (op_r == OP_DIVS);

    // Operand signs at the active width
    assign sa = is_signed && (is_div ? (len_r ? opa[31] : opa[15])
                                     : (len_r ? opa[15] : opa[7]));
    assign sb = is_signed && (len_r ? opb[15] : opb[7]);

    assign busy      = state != ST_IDLE;
    assign div_go    = (state == ST_RUN) && is_div;     // Start levels
    assign mul_go    = (state == ST_RUN) && !is_div;
    assign unit_busy = is_div ? div_busy : mul_busy;

    // ********************************************************
    // Sign restore
    // ********************************************************
    assign prod_s = neg_res ? -prod : prod;
    assign quot_s = neg_res ? -quot : quot;     // Also sign-extends byte results
    assign rem_s  = neg_rem ? -rem : rem;
    // Largest magnitude the signed quotient can hold
    assign qlim   = len_r ? (neg_res ? 16'h8000 : 16'h7FFF)
                          : (neg_res ? 16'h0080 : 16'h007F);
    assign sovf   = (op_r == OP_DIVS) && (quot > qlim);

    seq_div u_div (
        .clk      (clk),
        .rst      (rst),
        .start    (div_go),
        .len      (len_r),
        .dividend (a_r),
        .divisor  (b_r),
        .quot     (quot),
        .rem      (rem),
        .busy     (div_busy),
        .v        (div_v)
    );

    seq_mul u_mul (
        .clk          (clk),
        .rst          (rst),
        .start        (mul_go),
        .len          (len_r),
        .multiplicand (a_r[15:0]),
        .multiplier   (b_r),
        .product      (prod),
        .busy         (mul_busy)
    );

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= ST_IDLE;
            op_r     <= OP_MUL;
            len_r    <= 1'b0;
            launched <= 1'b0;
            done     <= 1'b0;
            v        <= 1'b0;
            res_lo   <= '0;
            res_hi   <= '0;
        end else begin
            case (state)
                ST_IDLE: if (start) begin
                    op_r  <= op;
                    len_r <= len;
                    done  <= 1'b0;
                    v     <= 1'b0;
                    state <= ST_PRE;
                end
                ST_PRE: begin
                    launched <= 1'b0;
                    state    <= ST_RUN;
                end
                ST_RUN: begin
                    launched <= 1'b1;
                    if (launched && !unit_busy)
                        state <= ST_POST;
                end
                default: begin      // ST_POST
                    if (is_div) begin
                        res_lo <= quot_s;
                        res_hi <= rem_s;
                        v      <= div_v || sovf;
                    end else begin
                        res_lo <= prod_s[15:0];
                        res_hi <= len_r ? prod_s[31:16] : 16'd0;  // Byte product fits low
                    end
                    done  <= 1'b1;
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // Operand capture
    always_ff @(posedge clk) begin
        if (state == ST_PRE) begin
            a_r     <= sa ? -opa : opa;
            b_r     <= sb ? -opb : opb;
            neg_res <= sa ^ sb;
            neg_rem <= sa;
        end
    end

endmodule

`default_nettype wire

/* src/muldiv_pkg.sv */
// Shared types and constants for the multiply/divide coprocessor
// Opcodes, sequencer states, register map and widths
`default_nettype none

package muldiv_pkg;

    // ********************************************************
    // Widths
    // ********************************************************
    localparam int APB_DW = 32;     // APB data bus
    localparam int RES_W  = 16;     // Each result half

    // Opcode as held in CTRL[1:0]
    typedef enum logic [1:0] {
        OP_MUL  = 2'd0,             // Unsigned multiply
        OP_MULS = 2'd1,             // Signed multiply
        OP_DIV  = 2'd2,             // Unsigned divide
        OP_DIVS = 2'd3              // Signed divide
    } muldiv_op_e;

    // Core sequencer
    typedef enum logic [1:0] {
        ST_IDLE = 2'd0,
        ST_PRE  = 2'd1,             // Latch operands, take magnitudes
        ST_RUN  = 2'd2,             // Selected unit running
        ST_POST = 2'd3              // Restore signs, write results
    } core_state_e;

    // ********************************************************
    // Register map, byte offsets
    // ********************************************************
    localparam logic [7:0] REG_OPA    = 8'h00;  // Dividend or multiplicand
    localparam logic [7:0] REG_OPB    = 8'h04;  // Divisor or multiplier
    localparam logic [7:0] REG_CTRL   = 8'h08;
    localparam logic [7:0] REG_STATUS = 8'h0C;  // {done, v, busy}
    localparam logic [7:0] REG_RES_LO = 8'h10;  // Quotient or product low
    localparam logic [7:0] REG_RES_HI = 8'h14;  // Remainder or product high

    // CTRL bit positions, opcode sits in 1:0
    localparam int CTRL_LEN   = 2;  // 1 = word
    localparam int CTRL_START = 8;  // Write only

endpackage

`default_nettype wire

/* src/seq_div.sv */
// Restoring sequential divider
// 32/16 word mode and 16/8 byte mode, one quotient bit per cycle
`timescale 1ns/1ps
`default_nettype none

module seq_div (
    input  logic        clk,
    input  logic        rst,
    input  logic        start,      // Level, acts on rising edge
    input  logic        len,        // 1 = word, 0 = byte
    input  logic [31:0] dividend,
    input  logic [15:0] divisor,
    output logic [15:0] quot,
    output logic [15:0] rem,
    output logic        busy,
    output logic        v           // Divide by zero or quotient too wide
);

    logic [31:0] dsh;               // Dividend bits still to come
    logic [15:0] dvs;               // Divisor, zero-extended in byte mode
    logic [15:0] prem;              // Partial remainder
    logic [31:0] q;                 // Full quotient for overflow check
    logic [4:0]  cnt;               // Step counter, done at 31
    logic        len_r;
    logic        start_l;

    logic        go;
    logic [16:0] trial;
    logic [16:0] diff;
    logic        ge;
    logic [31:0] q_nx;

    assign go    = start && !start_l;

    // One restoring step
    assign trial = {prem, dsh[31]};         // Remainder with next bit in
    assign diff  = trial - {1'b0, dvs};
    assign ge    = trial >= {1'b0, dvs};    // Subtract fits
    assign q_nx  = {q[30:0], ge};
    assign quot  = q[15:0];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            start_l <= 1'b0;
            busy    <= 1'b0;
            v       <= 1'b0;
            len_r   <= 1'b0;
            cnt     <= '0;
            q       <= '0;
            rem     <= '0;
        end else begin
            start_l <= start;
            if (go) begin
                busy  <= 1'b1;
                len_r <= len;
                q     <= '0;
                cnt   <= len ? 5'd0 : 5'd16;    // Byte mode runs last 16 steps
                v     <= len ? (divisor == 16'd0) : (divisor[7:0] == 8'd0);
            end else if (busy) begin
                q   <= q_nx;
                cnt <= cnt + 5'd1;
                if (&cnt) begin
                    busy <= 1'b0;
                    rem  <= ge ? diff[15:0] : trial[15:0];
                    // Quotient wider than the result
                    if (len_r ? (q_nx[31:16] != 16'd0) : (q_nx[15:8] != 8'd0))
                        v <= 1'b1;
                end
            end
        end
    end

    // Shift and subtract datapath
    always_ff @(posedge clk) begin
        if (go) begin
            dsh  <= len ? dividend : {dividend[15:0], 16'd0};
            dvs  <= len ? divisor : {8'd0, divisor[7:0]};
            prem <= '0;
        end else if (busy) begin
            dsh  <= {dsh[30:0], 1'b0};
            prem <= ge ? diff[15:0] : trial[15:0];     // Restore when short
        end
    end

endmodule

`default_nettype wire

/* src/seq_mul.sv */
// Shift-add sequential multiplier
// 16x16 word mode and 8x8 byte mode, one multiplier bit per cycle
`timescale 1ns/1ps
`default_nettype none

module seq_mul (
    input  logic        clk,
    input  logic        rst,
    input  logic        start,          // Level, acts on rising edge
    input  logic        len,            // 1 = word, 0 = byte
    input  logic [15:0] multiplicand,
    input  logic [15:0] multiplier,
    output logic [31:0] product,
    output logic        busy
);

    logic [31:0] acc;                   // {partial sum, multiplier left}
    logic [15:0] mcand;
    logic [3:0]  cnt;                   // Step counter, done at 15
    logic        len_r;
    logic        start_l;

    logic        go;
    logic [16:0] sum;

    assign go  = start && !start_l;

    // Add into upper half when multiplier LSB is set
    assign sum = {1'b0, acc[31:16]} + (acc[0] ? {1'b0, mcand} : 17'd0);

    // Byte mode ends 8 shifts short so its product sits at 23:8
    assign product = len_r ? acc : {16'd0, acc[23:8]};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            start_l <= 1'b0;
            busy    <= 1'b0;
            len_r   <= 1'b0;
            cnt     <= '0;
        end else begin
            start_l <= start;
            if (go) begin
                busy  <= 1'b1;
                len_r <= len;
                cnt   <= len ? 4'd0 : 4'd8;
            end else if (busy) begin
                cnt <= cnt + 4'd1;
                if (&cnt)
                    busy <= 1'b0;
            end
        end
    end

    // Accumulator
    always_ff @(posedge clk) begin
        if (go) begin
            acc   <= {16'd0, len ? multiplier : {8'd0, multiplier[7:0]}};
            mcand <= len ? multiplicand : {8'd0, multiplicand[7:0]};
        end else if (busy) begin
            acc <= {sum, acc[15:1]};    // Shift right one step
        end
    end

endmodule

`default_nettype wire

/* testbench/muldiv_model.svh */
// Reference model for the multiply/divide coprocessor
// Each function returns {v, res_hi, res_lo} as the registers show them
`ifndef MULDIV_MODEL_SVH
`define MULDIV_MODEL_SVH

// Unsigned divide, byte mode is a[15:0] / b[7:0]
function automatic logic [32:0] udiv_result(input logic len, input logic [31:0] a,
                                            input logic [15:0] b);
    longint unsigned n, d, q, r, qmax;
    n    = len ? a : {16'd0, a[15:0]};
    d    = len ? b : {8'd0, b[7:0]};
    qmax = len ? 65535 : 255;
    if (d == 0)
        return {1'b1, 32'd0};               // Divide by zero, results undefined
    q = n / d;
    r = n % d;
    return {q > qmax, r[15:0], q[15:0]};
endfunction

// Signed divide, quotient toward zero, remainder follows the dividend
function automatic logic [32:0] sdiv_result(input logic len, input logic [31:0] a,
                                            input logic [15:0] b);
    longint n, d, q, r, qmax;
    if (len) begin
        n    = $signed(a);
        d    = $signed(b);
        qmax = 32767;
    end else begin
        n    = $signed(a[15:0]);
        d    = $signed(b[7:0]);
        qmax = 127;
    end
    if (d == 0)
        return {1'b1, 32'd0};
    q = n / d;
    r = n % d;
    // Outside the signed range of the result width
    return {(q > qmax) || (q < -qmax - 1), r[15:0], q[15:0]};
endfunction

// Unsigned product, byte product lands in the low half
function automatic logic [31:0] umul_result(input logic len, input logic [15:0] a,
                                            input logic [15:0] b);
    if (len)
        return 32'(a) * 32'(b);
    return 32'(a[7:0]) * 32'(b[7:0]);
endfunction

// Signed product, byte mode gives 16 bits with the high half zero
function automatic logic [31:0] smul_result(input logic len, input logic [15:0] a,
                                            input logic [15:0] b);
    longint p;
    if (len) begin
        p = $signed(a) * $signed(b);
        return p[31:0];
    end
    p = $signed(a[7:0]) * $signed(b[7:0]);
    return {16'd0, p[15:0]};
endfunction

// Opcode dispatch
function automatic logic [32:0] model_result(input muldiv_op_e op, input logic len,
                                             input logic [31:0] a, input logic [15:0] b);
    case (op)
        OP_MUL:  return {1'b0, umul_result(len, a[15:0], b)};
        OP_MULS: return {1'b0, smul_result(len, a[15:0], b)};
        OP_DIV:  return udiv_result(len, a, b);
        default: return sdiv_result(len, a, b);
    endcase
endfunction

`endif

/* testbench/tb_muldiv.sv */
// Testbench for the APB multiply/divide coprocessor
// APB tasks, random operands and directed corner cases against the model
`timescale 1ns/1ps
`default_nettype none

module tb_muldiv
    import muldiv_pkg::*;
();

    localparam int ADDR_W   = 8;
    localparam int CLK_HALF = 5;            // 10 ns period
    localparam int POLL_MAX = 200;          // Cycles allowed per operation
    localparam int WAIT_MAX = 16;           // APB wait states tolerated
    localparam int N_RAND   = 40;

    logic              clk;
    logic              rst;
    logic              psel;
    logic              penable;
    logic              pwrite;
    logic [ADDR_W-1:0] paddr;
    logic [31:0]       pwdata;
    logic [31:0]       prdata;
    logic              pready;
    logic              pslverr;

    logic        slverr;                    // pslverr of last transfer
    int unsigned cycle_cnt;
    int          error_cnt, check_cnt;
    int          test_errs, test_checks;
    int          tests_run, tests_failed;
    string       cur_test;
    event        abort_ev;

    `include "muldiv_model.svh"

    muldiv_apb #(
        .ADDR_W (ADDR_W)
    ) dut0 (
        .clk     (clk),
        .rst     (rst),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr)
    );

    initial begin
        clk = 1'b0;
        forever #CLK_HALF clk = ~clk;
    end

    always @(posedge clk)
        cycle_cnt <= cycle_cnt + 1;

    // Timeout exit
    initial begin
        @(abort_ev);
        $display("TEST FAILED");
        $finish;
    end

    // ********************************************************
    // Bookkeeping
    // ********************************************************
    task automatic check_eq(input string what, input logic [31:0] exp, input logic [31:0] got);
        check_cnt++;
        test_checks++;
        assert (got === exp) else begin
            $display("Fail %s: %s expected %h actual %h", cur_test, what, exp, got);
            error_cnt++;
            test_errs++;
        end
    endtask

    task automatic abort_run(input string msg);
        $display("Error in %s: %s", cur_test, msg);
        error_cnt++;
        -> abort_ev;
        forever @(posedge clk);             // Park until the exit process ends the run
    endtask

    task automatic begin_test(input string name);
        cur_test    = name;
        test_errs   = 0;
        test_checks = 0;
    endtask

    task automatic end_test();
        tests_run++;
        if (test_errs == 0) begin
            $display("%-14s passed, %0d checks", cur_test, test_checks);
        end else begin
            tests_failed++;
            $display("%-14s failed, %0d of %0d checks wrong", cur_test, test_errs, test_checks);
        end
    endtask

    // ********************************************************
    // APB transfers
    // ********************************************************
    task automatic apb_xfer(input logic wr, input logic [ADDR_W-1:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rdata);
        int waits;
        @(posedge clk);
        #1;
        psel    = 1'b1;                     // Setup phase
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = wdata;
        @(posedge clk);
        #1;
        penable = 1'b1;                     // Access phase
        waits   = 0;
        @(negedge clk);
        while (!pready && waits < WAIT_MAX) begin
            @(negedge clk);
            waits++;
        end
        if (!pready)
            abort_run("pready stayed low in the APB access phase");
        rdata  = prdata;                    // Mid-cycle, settled
        slverr = pslverr;
        @(posedge clk);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_write(input logic [ADDR_W-1:0] addr, input logic [31:0] data);
        logic [31:0] unused;
        apb_xfer(1'b1, addr, data, unused);
    endtask

    task automatic apb_read(input logic [ADDR_W-1:0] addr, output logic [31:0] data);
        apb_xfer(1'b0, addr, 32'd0, data);
    endtask

    function automatic logic [31:0] ctrl_word(input muldiv_op_e op, input logic len,
                                              input logic go);
        return (32'(go) << CTRL_START) | (32'(len) << CTRL_LEN) | 32'(op);
    endfunction

    task automatic start_op(input muldiv_op_e op, input logic len);
        apb_write(REG_CTRL, ctrl_word(op, len, 1'b1));
    endtask

    // Poll STATUS until idle with done set
    task automatic wait_done(output logic [31:0] status);
        int unsigned t0;
        logic [31:0] st;
        t0 = cycle_cnt;
        apb_read(REG_STATUS, st);
        while ((st[0] || !st[2]) && (cycle_cnt - t0) < POLL_MAX)
            apb_read(REG_STATUS, st);
        if (st[0] || !st[2])
            abort_run("operation did not finish within 200 cycles");
        status = st;
    endtask

    task automatic compare_results(input logic [32:0] exp);
        logic [31:0] st, rd;
        wait_done(st);
        check_eq("STATUS.v", 32'(exp[32]), 32'(st[1]));
        if (!exp[32]) begin                 // Results only meaningful without overflow
            apb_read(REG_RES_LO, rd);
            check_eq("RES_LO", 32'(exp[15:0]), rd);
            apb_read(REG_RES_HI, rd);
            check_eq("RES_HI", 32'(exp[31:16]), rd);
        end
    endtask

    task automatic check_op(input muldiv_op_e op, input logic len, input logic [31:0] a,
                            input logic [15:0] b);
        apb_write(REG_OPA, a);
        apb_write(REG_OPB, {16'd0, b});
        start_op(op, len);
        compare_results(model_result(op, len, a, b));
    endtask

    // ********************************************************
    // Tests
    // ********************************************************
    task automatic reset_state();
        logic [31:0] rd;
        begin_test("reset_state");
        apb_read(REG_STATUS, rd);
        check_eq("STATUS after reset", 32'd0, rd);
        apb_read(REG_RES_LO, rd);
        check_eq("RES_LO after reset", 32'd0, rd);
        apb_read(REG_RES_HI, rd);
        check_eq("RES_HI after reset", 32'd0, rd);
        end_test();
    endtask

    task automatic udiv_random();
        logic [31:0] a;
        logic [15:0] d;
        begin_test("udiv_random");
        repeat (N_RAND) begin
            d = 16'($urandom_range(65535, 1));
            a = {16'($urandom) % d, 16'($urandom)};         // High half below divisor
            check_op(OP_DIV, 1'b1, a, d);
            d = {8'($urandom), 8'($urandom_range(255, 1))};
            a = {16'($urandom), 8'($urandom) % d[7:0], 8'($urandom)};
            check_op(OP_DIV, 1'b0, a, d);
        end
        end_test();
    endtask

    task automatic div_overflow();
        logic [31:0] a;
        logic [15:0] d;
        begin_test("div_overflow");
        check_op(OP_DIV, 1'b1, $urandom, 16'd0);
        check_op(OP_DIV, 1'b0, $urandom, {8'($urandom), 8'd0});
        repeat (N_RAND / 2) begin
            d = 16'($urandom_range(65535, 1));
            a = {16'($urandom_range(65535, d)), 16'($urandom)};   // Quotient above 16 bits
            check_op(OP_DIV, 1'b1, a, d);
            d = {8'($urandom), 8'($urandom_range(255, 1))};
            a = {16'($urandom), 8'($urandom_range(255, d[7:0])), 8'($urandom)};
            check_op(OP_DIV, 1'b0, a, d);
        end
        end_test();
    endtask

    task automatic sdiv_random();
        logic signed [31:0] sa;
        logic signed [15:0] sh;
        logic signed [7:0]  sq;
        begin_test("sdiv_random");
        // Range edges
        check_op(OP_DIVS, 1'b1, 32'hFFFF_8000, 16'h0001);
        check_op(OP_DIVS, 1'b1, 32'h0000_8000, 16'h0001);
        check_op(OP_DIVS, 1'b1, 32'h8000_0000, 16'hFFFF);
        check_op(OP_DIVS, 1'b0, 32'h0000_FF80, 16'h0001);
        check_op(OP_DIVS, 1'b0, 32'h0000_0080, 16'h0001);
        repeat (N_RAND * 2) begin
            sa = $urandom;
            sh = 16'($urandom);
            sa = sa >>> $urandom_range(31, 0);              // Spread of magnitudes
            sh = sh >>> $urandom_range(15, 0);
            check_op(OP_DIVS, 1'b1, sa, sh);
            sh = 16'($urandom);
            sq = 8'($urandom);
            sh = sh >>> $urandom_range(15, 0);
            sq = sq >>> $urandom_range(7, 0);
            check_op(OP_DIVS, 1'b0, {16'($urandom), sh}, {8'($urandom), sq});
        end
        end_test();
    endtask

    task automatic mul_random();
        begin_test("mul_random");
        check_op(OP_MULS, 1'b1, 32'h0000_8000, 16'h8000);
        check_op(OP_MULS, 1'b0, 32'h0000_0080, 16'h0080);
        repeat (N_RAND) begin
            check_op(OP_MUL,  1'b1, $urandom, 16'($urandom));
            check_op(OP_MUL,  1'b0, $urandom, 16'($urandom));
            check_op(OP_MULS, 1'b1, $urandom, 16'($urandom));
            check_op(OP_MULS, 1'b0, $urandom, 16'($urandom));
        end
        end_test();
    endtask

    task automatic backpressure();
        logic [31:0] a, st, rd;
        logic [15:0] d0, d1;
        logic [32:0] exp0, exp1;
        begin_test("backpressure");
        d0   = 16'($urandom_range(65535, 1));
        d1   = 16'($urandom_range(65535, 1));
        a    = {16'($urandom) % (d0 < d1 ? d0 : d1), 16'($urandom)};  // Fits either divisor
        exp0 = model_result(OP_DIV, 1'b1, a, d0);
        exp1 = model_result(OP_DIV, 1'b1, a, d1);
        apb_write(REG_OPA, a);
        apb_write(REG_OPB, {16'd0, d0});
        start_op(OP_DIV, 1'b1);
        apb_read(REG_STATUS, st);
        check_eq("busy while running", 32'd1, 32'(st[0]));
        apb_write(REG_CTRL, ctrl_word(OP_MUL, 1'b0, 1'b1));  // Dropped while busy
        apb_write(REG_OPB, {16'd0, d1});                     // Held for the next run
        compare_results(exp0);
        apb_read(REG_CTRL, rd);
        check_eq("CTRL after start while busy", ctrl_word(OP_DIV, 1'b1, 1'b0), rd);
        start_op(OP_DIV, 1'b1);
        compare_results(exp1);
        end_test();
    endtask

    task automatic unmapped_access();
        logic [31:0] a, rd;
        begin_test("unmapped");
        a = $urandom;
        apb_write(REG_OPA, a);
        check_eq("pslverr on OPA write", 32'd0, 32'(slverr));
        apb_read(8'h18, rd);
        check_eq("pslverr on read of 0x18", 32'd1, 32'(slverr));
        apb_write(8'h1C, ~a);
        check_eq("pslverr on write of 0x1C", 32'd1, 32'(slverr));
        apb_write(8'h02, ~a);               // Inside OPA word, not its offset
        check_eq("pslverr on write of 0x02", 32'd1, 32'(slverr));
        apb_read(REG_OPA, rd);
        check_eq("OPA after unmapped writes", a, rd);
        check_eq("pslverr on OPA read", 32'd0, 32'(slverr));
        end_test();
    endtask

    // ********************************************************
    // Main sequence
    // ********************************************************
    initial begin
        psel         = 1'b0;
        penable      = 1'b0;
        pwrite       = 1'b0;
        paddr        = '0;
        pwdata       = '0;
        rst          = 1'b1;
        slverr       = 1'b0;
        cycle_cnt    = 0;
        error_cnt    = 0;
        check_cnt    = 0;
        tests_run    = 0;
        tests_failed = 0;
        cur_test     = "reset";
        void'($urandom(32'hd3e3_effa));
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;

        reset_state();
        udiv_random();
        div_overflow();
        sdiv_random();
        mul_random();
        backpressure();
        unmapped_access();

        $display("Tests %0d run, %0d failed; checks %0d, errors %0d",
                 tests_run, tests_failed, check_cnt, error_cnt);
        if (error_cnt == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
